// ==== source/floo_flit_pkg.sv ====
package floo_flit_pkg;

  // One mesh coordinate covers up to 8 columns or rows
  localparam int unsigned COORD_W = 3;

  // Whole flit width, destination in the low bits
  localparam int unsigned FLIT_W = 32;

  // Destination field positions inside the flit
  localparam int unsigned DST_X_LSB = 0;
  localparam int unsigned DST_Y_LSB = DST_X_LSB + COORD_W;

  // Payload sits right above the destination id
  localparam int unsigned PAYLOAD_LSB = DST_Y_LSB + COORD_W;
  localparam int unsigned PAYLOAD_W = FLIT_W - PAYLOAD_LSB;

  // Single x or y coordinate
  typedef logic [COORD_W-1:0] coord_t;

  // Node position, x in the low half and y in the high half
  typedef logic [2*COORD_W-1:0] xy_id_t;

  // Opaque user data carried untouched through the router
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Complete single-flit packet
  typedef logic [FLIT_W-1:0] flit_t;

endpackage

// ==== source/floo_route_pkg.sv ====
package floo_route_pkg;

  // Local port plus the four mesh directions
  localparam int unsigned NUM_PORTS = 5;

  // Input buffer depth on every port
  localparam int unsigned IN_FIFO_DEPTH = 2;

  // FIFO pointer and occupancy widths
  localparam int unsigned IN_FIFO_PTR_W = (IN_FIFO_DEPTH > 1) ? $clog2(IN_FIFO_DEPTH) : 1;
  localparam int unsigned IN_FIFO_CNT_W = $clog2(IN_FIFO_DEPTH + 1);

  // Port index, also the bit position in a port mask
  typedef enum logic [2:0] {
    EJECT = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    SOUTH = 3'd3,
    WEST  = 3'd4
  } port_e;

  // One bit per port, one-hot when used as a route or grant
  typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

// ==== source/floo_in_fifo.sv ====
`timescale 1ns/100ps

module floo_in_fifo
  import floo_flit_pkg::*;
  import floo_route_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t data_i,
  output logic  head_valid_o,
  output flit_t head_flit_o,
  input  logic  head_ready_i
);

  // Storage, payload only so no reset
  flit_t mem_q [IN_FIFO_DEPTH];

  logic [IN_FIFO_PTR_W-1:0] wr_ptr_q;
  logic [IN_FIFO_PTR_W-1:0] rd_ptr_q;
  logic [IN_FIFO_CNT_W-1:0] count_q;
  logic                     push;
  logic                     pop;

  // Wrap at the last entry, depth need not be a power of two
  function automatic logic [IN_FIFO_PTR_W-1:0] ptr_inc(input logic [IN_FIFO_PTR_W-1:0] ptr);
    if (ptr == IN_FIFO_PTR_W'(IN_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Full buffer stops upstream, even if the head leaves this cycle
  assign ready_o = (count_q != IN_FIFO_CNT_W'(IN_FIFO_DEPTH));
  assign push    = valid_i & ready_o;

  // Show-ahead head, visible in the cycle after the write
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];
  assign pop          = head_valid_o & head_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop keep the count
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== source/floo_xy_route_select.sv ====
`timescale 1ns/100ps

module floo_xy_route_select
  import floo_flit_pkg::*;
  import floo_route_pkg::*;
(
  input  xy_id_t     xy_id_i,
  input  flit_t      head_flit_i,
  output port_mask_t route_o
);

  coord_t dst_x;
  coord_t dst_y;
  coord_t own_x;
  coord_t own_y;

  // Destination fields of the head flit
  assign dst_x = head_flit_i[DST_X_LSB +: COORD_W];
  assign dst_y = head_flit_i[DST_Y_LSB +: COORD_W];

  // Own position, x in the low half
  assign own_x = xy_id_i[COORD_W-1:0];
  assign own_y = xy_id_i[2*COORD_W-1:COORD_W];

  // Dimension order, resolve x first and only then y
  always_comb begin
    route_o = '0;
    if (dst_x > own_x) begin
      route_o[EAST] = 1'b1;
    end else if (dst_x < own_x) begin
      route_o[WEST] = 1'b1;
    end else if (dst_y > own_y) begin
      route_o[NORTH] = 1'b1;
    end else if (dst_y < own_y) begin
      route_o[SOUTH] = 1'b1;
    end else begin
      // Arrived, hand to the local endpoint
      route_o[EJECT] = 1'b1;
    end
  end

endmodule

// ==== source/floo_switch_alloc.sv ====
`timescale 1ns/100ps

module floo_switch_alloc
  import floo_route_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  port_mask_t                   head_valid_i,
  input  port_mask_t [NUM_PORTS-1:0]   route_i,
  input  port_mask_t                   slot_free_i,
  output port_mask_t [NUM_PORTS-1:0]   grant_o,
  output port_mask_t                   pop_o
);

  // Requests seen by each output, indexed [output][input]
  port_mask_t [NUM_PORTS-1:0] req;

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_req_out
    for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_req_in
      // No loopback and no turn from the y axis back onto x
      if ((i == o) || (((i == NORTH) || (i == SOUTH)) && ((o == EAST) || (o == WEST)))) begin : gen_pruned
        assign req[o][i] = 1'b0;
      end else begin : gen_legal
        assign req[o][i] = head_valid_i[i] & route_i[i][o];
      end
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_arb
    // Last input served on this output
    port_e last_q;
    port_e win;
    logic  win_valid;

    // Search starts one past the last winner and wraps around
    always_comb begin : rr_pick
      int unsigned idx;
      win       = last_q;
      win_valid = 1'b0;
      for (int unsigned k = 1; k <= NUM_PORTS; k++) begin
        idx = (int'(last_q) + k) % NUM_PORTS;
        if (!win_valid && req[o][idx]) begin
          win       = port_e'(idx);
          win_valid = 1'b1;
        end
      end
    end

    // Grant only into an empty or draining slot
    assign grant_o[o] = (win_valid && slot_free_i[o]) ? (port_mask_t'(1'b1) << win) : '0;

    // Pointer moves only when a grant is actually issued
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        last_q <= EJECT;
      end else if (|grant_o[o]) begin
        last_q <= win;
      end
    end
  end

  // An input has one route, so at most one output grants it
  always_comb begin
    pop_o = '0;
    for (int unsigned o = 0; o < NUM_PORTS; o++) begin
      pop_o |= grant_o[o];
    end
  end

endmodule

// ==== source/floo_crossbar.sv ====
`timescale 1ns/100ps

module floo_crossbar
  import floo_flit_pkg::*;
  import floo_route_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  flit_t      [NUM_PORTS-1:0] head_flit_i,
  input  port_mask_t [NUM_PORTS-1:0] grant_i,
  output port_mask_t                 slot_free_o,
  output port_mask_t                 valid_o,
  input  port_mask_t                 ready_i,
  output flit_t      [NUM_PORTS-1:0] data_o
);

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    flit_t [NUM_PORTS-1:0] masked;
    flit_t                 mux_flit;
    logic                  slot_valid_q;
    flit_t                 slot_data_q;

    // AND stage, pruned legs are constant zero and drop out
    for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_in
      if ((i == o) || (((i == NORTH) || (i == SOUTH)) && ((o == EAST) || (o == WEST)))) begin : gen_no_conn
        assign masked[i] = '0;
      end else begin : gen_conn
        assign masked[i] = grant_i[o][i] ? head_flit_i[i] : '0;
      end
    end

    // OR stage, grant is one-hot so this is a clean mux
    always_comb begin
      mux_flit = '0;
      for (int unsigned i = 0; i < NUM_PORTS; i++) begin
        mux_flit |= masked[i];
      end
    end

    // Slot can take a new flit when empty or sending this cycle
    assign slot_free_o[o] = ~slot_valid_q | ready_i[o];
    assign valid_o[o]     = slot_valid_q;
    assign data_o[o]      = slot_data_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        slot_valid_q <= 1'b0;
      end else if (|grant_i[o]) begin
        slot_valid_q <= 1'b1;
      end else if (ready_i[o]) begin
        slot_valid_q <= 1'b0;
      end
    end

    // Data held while stalled, only a grant replaces it
    always_ff @(posedge clk_i) begin
      if (|grant_i[o]) begin
        slot_data_q <= mux_flit;
      end
    end
  end

endmodule

// ==== source/floo_router.sv ====
`timescale 1ns/100ps

module floo_router
  import floo_flit_pkg::*;
  import floo_route_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  xy_id_t                     xy_id_i,
  input  port_mask_t                 valid_i,
  output port_mask_t                 ready_o,
  input  flit_t      [NUM_PORTS-1:0] data_i,
  output port_mask_t                 valid_o,
  input  port_mask_t                 ready_i,
  output flit_t      [NUM_PORTS-1:0] data_o
);

  // Head of each input buffer
  port_mask_t                 head_valid;
  flit_t      [NUM_PORTS-1:0] head_flit;

  // One-hot route per input
  port_mask_t [NUM_PORTS-1:0] route;

  // Allocator results, grant indexed by output
  port_mask_t [NUM_PORTS-1:0] grant;
  port_mask_t                 pop;
  port_mask_t                 slot_free;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
    floo_in_fifo i_in_fifo (
      .clk_i        ( clk_i         ),
      .rst_n_i      ( rst_n_i       ),
      .valid_i      ( valid_i[p]    ),
      .ready_o      ( ready_o[p]    ),
      .data_i       ( data_i[p]     ),
      .head_valid_o ( head_valid[p] ),
      .head_flit_o  ( head_flit[p]  ),
      .head_ready_i ( pop[p]        )
    );

    floo_xy_route_select i_route_select (
      .xy_id_i     ( xy_id_i      ),
      .head_flit_i ( head_flit[p] ),
      .route_o     ( route[p]     )
    );
  end

  // Grants issued in the same cycle as the head appears
  floo_switch_alloc i_switch_alloc (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .head_valid_i ( head_valid ),
    .route_i      ( route      ),
    .slot_free_i  ( slot_free  ),
    .grant_o      ( grant      ),
    .pop_o        ( pop        )
  );

  // Output slots register the granted flit
  floo_crossbar i_crossbar (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .head_flit_i ( head_flit ),
    .grant_i     ( grant     ),
    .slot_free_o ( slot_free ),
    .valid_o     ( valid_o   ),
    .ready_i     ( ready_i   ),
    .data_o      ( data_o    )
  );

endmodule

// ==== tb/floo_router_assertions.sv ====
`timescale 1ns/100ps

module floo_router_assertions
  import floo_flit_pkg::*;
  import floo_route_pkg::*;
(
  input logic                       clk_i,
  input logic                       rst_n_i,
  input port_mask_t                 slot_valid_i,
  input port_mask_t                 slot_ready_i,
  input flit_t      [NUM_PORTS-1:0] slot_data_i,
  input port_mask_t [NUM_PORTS-1:0] grant_i
);

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    // Stalled slot keeps its flit until the sink takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slot_valid_i[o] && !slot_ready_i[o] |=> slot_valid_i[o] && $stable(slot_data_i[o]))
      else $error("output %0d dropped or changed a stalled flit", o);

    // At most one input wins an output
    assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(grant_i[o]))
      else $error("output %0d granted several inputs: %b", o, grant_i[o]);

    for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_in
      if ((i == o) || (((i == NORTH) || (i == SOUTH)) && ((o == EAST) || (o == WEST)))) begin : gen_pruned
        assert property (@(posedge clk_i) disable iff (!rst_n_i) !grant_i[o][i])
          else $error("pruned grant from input %0d to output %0d", i, o);
      end
    end
  end

endmodule

// Crossbar grant_i is the allocator's grant_o
bind floo_crossbar floo_router_assertions i_assertions (
  .clk_i        ( clk_i   ),
  .rst_n_i      ( rst_n_i ),
  .slot_valid_i ( valid_o ),
  .slot_ready_i ( ready_i ),
  .slot_data_i  ( data_o  ),
  .grant_i      ( grant_i )
);

// ==== tb/tb_floo_router.sv ====
`timescale 1ns/100ps

module tb_floo_router
  import floo_flit_pkg::*;
  import floo_route_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int RAND_FLITS = 300;
  localparam int STALL_FLITS = 200;
  localparam int STREAM_FLITS = 20;
  localparam int TOTAL_FLITS = NUM_PORTS + RAND_FLITS + STALL_FLITS + 2 * STREAM_FLITS;
  localparam coord_t OWN_X = 3'd3;
  localparam coord_t OWN_Y = 3'd3;

  logic                       clk_i;
  logic                       rst_n_i;
  port_mask_t                 valid_i;
  port_mask_t                 ready_o;
  port_mask_t                 valid_o;
  port_mask_t                 ready_i;
  flit_t      [NUM_PORTS-1:0] data_i;
  flit_t      [NUM_PORTS-1:0] data_o;

  // Flits waiting per input, expected flits per output and input
  flit_t      tx_q [NUM_PORTS][$];
  flit_t      sb_q [NUM_PORTS][NUM_PORTS][$];
  integer     seed;
  int         seq_cnt;
  int         err_val;
  int         err_other;
  int         east_cnt;
  logic       bp_on;
  logic       log_east;
  logic       saw_full;
  logic       have_last;
  logic [2:0] last_src;

  floo_router i_dut (
    .clk_i   ( clk_i          ),
    .rst_n_i ( rst_n_i        ),
    .xy_id_i ( {OWN_Y, OWN_X} ),
    .valid_i ( valid_i        ),
    .ready_o ( ready_o        ),
    .data_i  ( data_i         ),
    .valid_o ( valid_o        ),
    .ready_i ( ready_i        ),
    .data_o  ( data_o         )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // XY rule, x settled before y
  function automatic port_e ref_route(coord_t dx, coord_t dy);
    if (dx > OWN_X) return EAST;
    if (dx < OWN_X) return WEST;
    if (dy > OWN_Y) return NORTH;
    if (dy < OWN_Y) return SOUTH;
    return EJECT;
  endfunction

  // No U-turn and no turn from y back onto x
  function automatic logic route_legal(port_e in_p, port_e out_p);
    return (in_p != out_p) &&
           !(((in_p == NORTH) || (in_p == SOUTH)) && ((out_p == EAST) || (out_p == WEST)));
  endfunction

  // Source port in the low payload bits, running number above
  task automatic queue_flit(port_e src, coord_t dx, coord_t dy);
    flit_t f;
    f = '0;
    f[DST_X_LSB +: COORD_W] = dx;
    f[DST_Y_LSB +: COORD_W] = dy;
    f[PAYLOAD_LSB +: 3] = src;
    f[PAYLOAD_LSB + 3 +: PAYLOAD_W - 3] = seq_cnt[PAYLOAD_W-4:0];
    seq_cnt++;
    tx_q[src].push_back(f);
  endtask

  // Random input among those allowed to reach this destination
  task automatic queue_to(coord_t dx, coord_t dy);
    port_e in_p;
    do begin
      in_p = port_e'(3'({$random(seed)} % NUM_PORTS));
    end while (!route_legal(in_p, ref_route(dx, dy)));
    queue_flit(in_p, dx, dy);
  endtask

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      n += tx_q[p].size();
      for (int o = 0; o < NUM_PORTS; o++) begin
        n += sb_q[o][p].size();
      end
    end
    return n;
  endfunction

  task automatic wait_drain();
    while (pending_flits() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // Input side, valid and data held until accepted
  always @(posedge clk_i) begin
    flit_t acc;
    port_e out_p;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (valid_i[p] && ready_o[p]) begin
        acc = data_i[p];
        out_p = ref_route(acc[DST_X_LSB +: COORD_W], acc[DST_Y_LSB +: COORD_W]);
        sb_q[out_p][p].push_back(acc);
        void'(tx_q[p].pop_front());
      end
      if (tx_q[p].size() > 0) begin
        valid_i[p] <= 1'b1;
        data_i[p]  <= tx_q[p][0];
      end else begin
        valid_i[p] <= 1'b0;
      end
    end
  end

  // Sink side, random stalls only while back-pressure is on
  always @(posedge clk_i) begin
    ready_i <= bp_on ? port_mask_t'($random(seed)) : '1;
  end

  // Compare every output transfer with the head of its queue
  always @(posedge clk_i) begin
    logic [2:0] src;
    flit_t      exp_flit;
    if (rst_n_i) begin
      if (bp_on && (ready_o != '1)) saw_full = 1'b1;
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (valid_o[o] && ready_i[o]) begin
          src = data_o[o][PAYLOAD_LSB +: 3];
          if ((src > 3'd4) || (sb_q[o][src].size() == 0)) begin
            err_other++;
            $display("unexpected flit %h on output %0d at %0t", data_o[o], o, $time);
          end else begin
            exp_flit = sb_q[o][src].pop_front();
            if (data_o[o] != exp_flit) begin
              err_val++;
              $display("error at %0t: data_o[%0d] got %h expected %h",
                       $time, o, data_o[o], exp_flit);
            end
          end
          // Two steady sources on East must take turns
          if (log_east && (o == int'(EAST))) begin
            east_cnt++;
            if (have_last && (src == last_src)) begin
              err_val++;
              $display("error at %0t: data_o[%0d] source got %0d expected %0d",
                       $time, o, src, (last_src == EJECT) ? WEST : EJECT);
            end
            have_last = 1'b1;
            last_src  = src;
          end
        end
      end
    end
  end

  initial begin
    #((TOTAL_FLITS * 40 + 8) * CLK_PERIOD);
    $display("watchdog expired with %0d flits still pending", pending_flits());
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] r;
    seed = 35;
    seq_cnt = 0;
    err_val = 0;
    err_other = 0;
    east_cnt = 0;
    bp_on = 1'b0;
    log_east = 1'b0;
    saw_full = 1'b0;
    have_last = 1'b0;
    last_src = '0;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    valid_i = '0;
    data_i = '0;
    ready_i = '1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    // Idle router, slots empty and buffers open
    if (valid_o != '0) begin
      err_val++;
      $display("error at %0t: valid_o got %b expected %b", $time, valid_o, 5'b00000);
    end
    if (ready_o != '1) begin
      err_val++;
      $display("error at %0t: ready_o got %b expected %b", $time, ready_o, 5'b11111);
    end
    // One flit to each neighbour and to the local port
    queue_to(3'd3, 3'd3);
    queue_to(3'd3, 3'd4);
    queue_to(3'd4, 3'd3);
    queue_to(3'd3, 3'd2);
    queue_to(3'd2, 3'd3);
    wait_drain();
    repeat (RAND_FLITS) begin
      r = $random(seed);
      queue_to(r[2:0], r[5:3]);
    end
    wait_drain();
    bp_on = 1'b1;
    repeat (STALL_FLITS) begin
      r = $random(seed);
      queue_to(r[2:0], r[5:3]);
    end
    wait_drain();
    bp_on = 1'b0;
    if (!saw_full) begin
      err_other++;
      $display("ready_o never went low under back-pressure");
    end
    // Eject and West both stream to East, x above own column
    log_east = 1'b1;
    repeat (STREAM_FLITS) begin
      r = $random(seed);
      queue_flit(EJECT, {1'b1, r[1:0]}, r[4:2]);
      queue_flit(WEST, {1'b1, r[6:5]}, r[9:7]);
    end
    wait_drain();
    log_east = 1'b0;
    if (east_cnt != 2 * STREAM_FLITS) begin
      err_other++;
      $display("East carried %0d flits in the stream test instead of %0d",
               east_cnt, 2 * STREAM_FLITS);
    end
    $display("error counts: %0d wrong values, %0d other failures", err_val, err_other);
    if ((err_val + err_other) == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/floo_flit_pkg.sv
source/floo_route_pkg.sv
source/floo_in_fifo.sv
source/floo_xy_route_select.sv
source/floo_switch_alloc.sv
source/floo_crossbar.sv
source/floo_router.sv
tb/floo_router_assertions.sv
tb/tb_floo_router.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_floo_router
RTL_TOP    := floo_router
FILELIST   := build.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
